// File: hw/memPkg.sv
package memPkg;

    // Size of the chip RAM word store
    localparam int ramDepth    = 64;
    localparam int ramAddrBits = 6;
    localparam int ramWordBits = 32;

    // Byte lanes of a 32-bit word, one bit per lane
    // A set bit enables the lane and uu carries data bits 31 to 24
    typedef struct packed {
        logic uu;
        logic um;
        logic lm;
        logic ll;
    } laneSetT;

    // States of the store sequencer
    // The access itself happens in stAccess and stHold waits for release
    typedef enum logic [1:0] {
        stIdle   = 2'b00,
        stAccess = 2'b01,
        stHold   = 2'b10
    } storeStateT;

endpackage

// File: hw/busPkg.sv
package busPkg;

    import memPkg::*;

    // Bus geometry seen by the CPU and by the DMA engine
    localparam int busDataBits = 32;
    localparam int busAddrBits = 8;

    // Transfer size as driven on SIZ1 and SIZ0
    // A code of zero means a full longword, as on the 68030
    typedef enum logic [1:0] {
        sizeLong  = 2'b00,
        sizeByte  = 2'b01,
        sizeWord  = 2'b10,
        sizeThree = 2'b11
    } busSizeT;

    // Direction of the bus cycle
    typedef enum logic {
        opRead  = 1'b0,
        opWrite = 1'b1
    } accessOpT;

    // One bus cycle as presented by the CPU or the DMA engine
    // The strobes casU and casL are active low and only matter when dma is set
    // A low dbEn steers a DMA cycle to the high word of the longword
    typedef struct packed {
        accessOpT               op;
        busSizeT                size;
        logic [busAddrBits-1:0] addr;
        logic [busDataBits-1:0] wrData;
        logic                   dma;
        logic                   casU;
        logic                   casL;
        logic                   dbEn;
    } busCycleT;

    // Result handed back once the access has finished
    // Both lane sets travel with the data so the requester can check them
    typedef struct packed {
        logic [busDataBits-1:0] rdData;
        laneSetT                busLanes;
        laneSetT                ramLanes;
    } busReplyT;

endpackage

// File: hw/cycleIntake.sv
module cycleIntake import busPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     cmdReq,
    output logic     cmdAck,
    input  busCycleT cmdCycle,
    input  logic     releaseCycle,
    output busCycleT heldCycle,
    output logic     cycleValid
);

    // A new cycle is taken only when nothing is held and the previous
    // handshake has fully returned to zero
    logic takeCycle;

    assign takeCycle = cmdReq && !cmdAck && !cycleValid;

    //////////////////////////////////////////////////////////////////////
    // Four-phase acknowledge and cycle ownership
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cmdAck     <= 1'b0;
            cycleValid <= 1'b0;
        end else begin
            // Ack follows the request down one clock after it drops
            if (takeCycle) begin
                cmdAck <= 1'b1;
            end else if (!cmdReq) begin
                cmdAck <= 1'b0;
            end
            // The cycle stays owned until the reply side lets it go
            if (takeCycle) begin
                cycleValid <= 1'b1;
            end else if (releaseCycle) begin
                cycleValid <= 1'b0;
            end
        end
    end

    // The requester keeps its data stable until ack, so sample on take
    always_ff @(posedge clk) begin
        if (takeCycle) begin
            heldCycle <= cmdCycle;
        end
    end

    // Ack must be the answer to a request seen while the intake was free
    ackFollowsReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(cmdAck) |-> $past(cmdReq) && !$past(cycleValid)
    );

endmodule

// File: hw/byteEnable.sv
module byteEnable import memPkg::*, busPkg::*; (
    input  busCycleT cycle,
    output laneSetT  busLanes,
    output laneSetT  ramLanes
);

    // Lane numbers run from 0 for uu to 3 for ll, matching byte offsets
    logic [2:0] byteCount;
    logic [2:0] firstLane;
    logic [2:0] lastLane;
    logic [3:0] spanMask;

    //////////////////////////////////////////////////////////////////////
    // Data bus lanes for the SDRAM and PCI side
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // A size code of zero is a longword, the others count bytes
        byteCount = (cycle.size == sizeLong) ? 3'd4 : {1'b0, cycle.size};
        firstLane = {1'b0, cycle.addr[1:0]};
        lastLane  = firstLane + byteCount - 3'd1;
        // Anything past lane 3 would belong to the next longword and is dropped
        for (int lane = 0; lane < 4; lane++) begin
            spanMask[lane] = (lane >= firstLane) && (lane <= lastLane);
        end
    end

    always_comb begin
        if (cycle.op == opRead) begin
            // Reads fetch the whole longword and let the CPU pick its bytes
            busLanes = '{uu: 1'b1, um: 1'b1, lm: 1'b1, ll: 1'b1};
        end else begin
            busLanes = '{uu: spanMask[0], um: spanMask[1],
                         lm: spanMask[2], ll: spanMask[3]};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Chip RAM lanes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!cycle.dma) begin
            ramLanes = busLanes;
        end else if (!cycle.dbEn) begin
            // High word, so the column strobes land on the upper two lanes
            ramLanes = '{uu: !cycle.casU, um: !cycle.casL, lm: 1'b0, ll: 1'b0};
        end else begin
            ramLanes = '{uu: 1'b0, um: 1'b0, lm: !cycle.casU, ll: !cycle.casL};
        end
    end

    // A CPU write always touches at least the byte at its own offset
    always_comb begin
        if (cycle.op == opWrite && !cycle.dma) begin
            cpuWriteHasLane: assert final (busLanes != '0);
        end
    end

endmodule

// File: hw/chipRamStore.sv
module chipRamStore import memPkg::*, busPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  busCycleT    cycle,
    input  logic        cycleValid,
    input  laneSetT     ramLanes,
    output logic        accessDone,
    output logic [31:0] rdData
);

    storeStateT             state;
    logic [ramAddrBits-1:0] wordAddr;

    // Chip RAM contents, one longword per entry
    logic [ramWordBits-1:0] ramWords [ramDepth];

    // Byte address bits 1 and 0 only pick lanes, so the word index starts at 2
    assign wordAddr = cycle.addr[7:2];

    //////////////////////////////////////////////////////////////////////
    // Sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= stIdle;
            accessDone <= 1'b0;
        end else begin
            accessDone <= 1'b0;
            case (state)
                stIdle: begin
                    if (cycleValid) begin
                        state <= stAccess;
                    end
                end
                stAccess: begin
                    // The word is written or read on this edge, so report it now
                    state      <= stHold;
                    accessDone <= 1'b1;
                end
                stHold: begin
                    // Wait here so one held cycle gives exactly one access
                    if (!cycleValid) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Word access
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == stAccess) begin
            if (cycle.op == opWrite) begin
                // Only the enabled lanes change, the rest keep their old bytes
                if (ramLanes.uu) begin
                    ramWords[wordAddr][31:24] <= cycle.wrData[31:24];
                end
                if (ramLanes.um) begin
                    ramWords[wordAddr][23:16] <= cycle.wrData[23:16];
                end
                if (ramLanes.lm) begin
                    ramWords[wordAddr][15:8] <= cycle.wrData[15:8];
                end
                if (ramLanes.ll) begin
                    ramWords[wordAddr][7:0] <= cycle.wrData[7:0];
                end
            end else begin
                rdData <= ramWords[wordAddr];
            end
        end
    end

    // Done marks the first clock of stHold and never repeats inside it
    doneOnEntry: assert property (
        @(posedge clk) disable iff (!rstN)
        accessDone |-> state == stHold && $past(state) == stAccess
    );

endmodule

// File: hw/cycleReply.sv
module cycleReply import memPkg::*, busPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        accessDone,
    input  logic [31:0] rdData,
    input  laneSetT     busLanes,
    input  laneSetT     ramLanes,
    output logic        rspReq,
    input  logic        rspAck,
    output busReplyT    rspData,
    output logic        releaseCycle
);

    // High from the finished access until the reply handshake is back to zero
    logic replyBusy;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rspReq       <= 1'b0;
            replyBusy    <= 1'b0;
            releaseCycle <= 1'b0;
        end else begin
            releaseCycle <= 1'b0;
            if (accessDone) begin
                rspReq    <= 1'b1;
                replyBusy <= 1'b1;
            end else if (rspReq && rspAck) begin
                rspReq <= 1'b0;
            end else if (replyBusy && !rspReq && !rspAck) begin
                // Ack has dropped so the intake may take the next cycle
                replyBusy    <= 1'b0;
                releaseCycle <= 1'b1;
            end
        end
    end

    // Reply is captured once and held through the whole handshake
    always_ff @(posedge clk) begin
        if (accessDone) begin
            rspData <= '{rdData: rdData, busLanes: busLanes, ramLanes: ramLanes};
        end
    end

    replyStable: assert property (
        @(posedge clk) disable iff (!rstN)
        rspReq && $past(rspReq) |-> $stable(rspData)
    );

    // The intake must not let a second access finish while a reply is open
    oneInFlight: assert property (
        @(posedge clk) disable iff (!rstN)
        accessDone |-> !replyBusy
    );

endmodule

// File: hw/chipRamTop.sv
module chipRamTop import memPkg::*, busPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  logic     cmdReq,
    output logic     cmdAck,
    input  busCycleT cmdCycle,
    output logic     rspReq,
    input  logic     rspAck,
    output busReplyT rspData
);

    busCycleT    heldCycle;
    logic        cycleValid;
    laneSetT     busLanes;
    laneSetT     ramLanes;
    logic        accessDone;
    logic [31:0] rdData;
    logic        releaseCycle;

    // Intake holds one cycle, the decode and store work from that copy
    cycleIntake intake_i (
        .clk, .rstN, .cmdReq, .cmdAck, .cmdCycle,
        .releaseCycle, .heldCycle, .cycleValid
    );

    byteEnable lanes_i (.cycle(heldCycle), .busLanes, .ramLanes);

    chipRamStore store_i (
        .clk, .rstN, .cycle(heldCycle), .cycleValid,
        .ramLanes, .accessDone, .rdData
    );

    // Reply side frees the intake only once its own handshake is done
    cycleReply reply_i (
        .clk, .rstN, .accessDone, .rdData, .busLanes, .ramLanes,
        .rspReq, .rspAck, .rspData, .releaseCycle
    );

endmodule

// File: bench/chipRamBench.sv
module chipRamBench import memPkg::*, busPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // Fill, size by offset sweep, then random traffic
    localparam int sweepCycles     = 32;
    localparam int randomCycles    = 200;
    // Ten clocks of handshake and store latency, up to three of ack delay, plus slack
    localparam int cyclesPerAccess = 16;
    localparam int cycleLimit      =
        (ramDepth + sweepCycles + randomCycles) * cyclesPerAccess + 20;

    logic     clk;
    logic     rstN;
    logic     cmdReq;
    logic     cmdAck;
    busCycleT cmdCycle;
    logic     rspReq;
    logic     rspAck;
    busReplyT rspData;

    // Reference copy of chip RAM and the replies still owed by the DUT
    logic [31:0] refMem [ramDepth];
    busReplyT    replyQ [$];
    bit          readQ [$];
    string       nameQ [$];

    busReplyT    expReply;
    logic        checkNow;
    logic        checkRead;
    string       checkName;
    logic [15:0] lfsr;
    int          outstanding;
    int          cycleCount;
    int          mismatchCount = 0;
    int          protocolCount = 0;

    chipRamTop dut_i (
        .clk, .rstN, .cmdReq, .cmdAck, .cmdCycle, .rspReq, .rspAck, .rspData
    );

    always #20 clk = ~clk;

    // Hard stop so a stuck handshake cannot hang the run
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            $display("Errors: %0d mismatch, %0d protocol", mismatchCount, protocolCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit taken
    function automatic logic [31:0] drawBits(int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            value    = {value[30:0], lfsr[15]};
            lfsr     = {lfsr[14:0], feedback};
        end
        return value;
    endfunction

    // A run of ones as long as the transfer, shifted right by the offset
    // Bits that fall off the low end belong to the next longword
    function automatic laneSetT spanLanes(busCycleT c);
        logic [3:0] run;
        if (c.op == opRead) begin
            return laneSetT'(4'b1111);
        end
        case (c.size)
            sizeByte: run = 4'b1000;
            sizeWord: run = 4'b1100;
            sizeThree: run = 4'b1110;
            default: run = 4'b1111;
        endcase
        return laneSetT'(run >> c.addr[1:0]);
    endfunction

    // DMA strobes are active low and dbEn picks the word half
    function automatic laneSetT chipLanes(busCycleT c, laneSetT cpuLanes);
        if (!c.dma) begin
            return cpuLanes;
        end
        if (c.dbEn) begin
            return laneSetT'({2'b00, !c.casU, !c.casL});
        end
        return laneSetT'({!c.casU, !c.casL, 2'b00});
    endfunction

    function automatic busCycleT cpuCycle(accessOpT op, busSizeT size, logic [7:0] addr,
                                          logic [31:0] data);
        return '{op: op, size: size, addr: addr, wrData: data,
                 dma: 1'b0, casU: 1'b1, casL: 1'b1, dbEn: 1'b1};
    endfunction

    // Every byte of the fill word depends on the full word address
    function automatic logic [31:0] fillWord(logic [5:0] w);
        return {8'hc3 ^ {2'b00, w}, {2'b00, w}, ~{2'b00, w}, 8'h5a + {2'b00, w}};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic issueCycle(input busCycleT c, input string name);
        busReplyT   want;
        logic [5:0] word;
        word     = c.addr[7:2];
        cmdCycle = c;
        cmdReq   = 1'b1;
        do begin
            @(posedge clk);
            #5;
        end while (!cmdAck);
        // Accepted, so this cycle now sits ahead of every later one
        want.busLanes = spanLanes(c);
        want.ramLanes = chipLanes(c, want.busLanes);
        want.rdData   = refMem[word];
        if (c.op == opWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (want.ramLanes[3 - lane]) begin
                    refMem[word][31 - 8 * lane -: 8] = c.wrData[31 - 8 * lane -: 8];
                end
            end
        end
        replyQ.push_back(want);
        readQ.push_back(c.op == opRead);
        nameQ.push_back(name);
        outstanding++;
        cmdReq = 1'b0;
        do begin
            @(posedge clk);
            #5;
        end while (cmdAck);
    endtask

    task automatic randomCycle();
        busCycleT    c;
        logic [31:0] word;
        logic [31:0] offset;
        c.op     = accessOpT'(drawBits(1));
        c.size   = busSizeT'(drawBits(2));
        word     = drawBits(3);
        offset   = drawBits(2);
        // Eight words only, so reads often land on freshly written data
        c.addr   = {3'b000, word[2:0], offset[1:0]};
        c.wrData = drawBits(32);
        c.dma    = (drawBits(2) == 0);
        c.casU   = 1'(drawBits(1));
        c.casL   = 1'(drawBits(1));
        c.dbEn   = 1'(drawBits(1));
        issueCycle(c, {c.dma ? "dma" : "cpu", c.op == opWrite ? "Write" : "Read"});
    endtask

    // Takes each reply, loads the expected copy and holds ack off for a while
    task automatic serveReplies();
        int delay;
        forever begin
            @(posedge clk);
            #5;
            if (rspReq) begin
                if (replyQ.size() == 0) begin
                    protocolCount++;
                    $display("Reply arrived with no cycle outstanding");
                end else begin
                    expReply  = replyQ.pop_front();
                    checkRead = readQ.pop_front();
                    checkName = nameQ.pop_front();
                end
                checkNow = 1'b1;
                delay    = drawBits(2);
                @(posedge clk);
                #5;
                checkNow = 1'b0;
                repeat (delay) begin
                    @(posedge clk);
                    #5;
                end
                rspAck = 1'b1;
                do begin
                    @(posedge clk);
                    #5;
                end while (rspReq);
                rspAck = 1'b0;
                outstanding--;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        cmdReq      = 1'b0;
        cmdCycle    = '0;
        rspAck      = 1'b0;
        expReply    = '0;
        checkNow    = 1'b0;
        checkRead   = 1'b0;
        checkName   = "";
        lfsr        = 16'd9;
        outstanding = 0;
        cycleCount  = 0;
        repeat (2) @(posedge clk);
        #5;
        rstN = 1'b1;
        fork
            serveReplies();
        join_none
        for (int w = 0; w < ramDepth; w++) begin
            issueCycle(cpuCycle(opWrite, sizeLong, {w[5:0], 2'b00}, fillWord(w[5:0])), "fill");
        end
        // Every size at every offset, each write read back from words 16 to 31
        for (int i = 0; i < 16; i++) begin
            issueCycle(cpuCycle(opWrite, busSizeT'(i[3:2]), {2'b01, i[3:0], i[1:0]},
                                drawBits(32)), "sweepWrite");
            issueCycle(cpuCycle(opRead, sizeLong, {2'b01, i[3:0], 2'b00}, '0), "sweepRead");
        end
        repeat (randomCycles) begin
            randomCycle();
        end
        while (outstanding != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Errors: %0d mismatch, %0d protocol", mismatchCount, protocolCount);
        if (mismatchCount + protocolCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    rdDataMatches: assert property (
        @(posedge clk) disable iff (!rstN)
        checkNow && checkRead |-> rspData.rdData === expReply.rdData
    ) else begin
        mismatchCount++;
        $display("Mismatch %s rdData: expected %h, actual %h",
                 checkName, expReply.rdData, $sampled(rspData.rdData));
    end

    busLanesMatch: assert property (
        @(posedge clk) disable iff (!rstN)
        checkNow |-> rspData.busLanes === expReply.busLanes
    ) else begin
        mismatchCount++;
        $display("Mismatch %s busLanes: expected %b, actual %b",
                 checkName, expReply.busLanes, $sampled(rspData.busLanes));
    end

    ramLanesMatch: assert property (
        @(posedge clk) disable iff (!rstN)
        checkNow |-> rspData.ramLanes === expReply.ramLanes
    ) else begin
        mismatchCount++;
        $display("Mismatch %s ramLanes: expected %b, actual %b",
                 checkName, expReply.ramLanes, $sampled(rspData.ramLanes));
    end

    idleInReset: assert property (@(posedge clk) $rose(rstN) |-> !cmdAck && !rspReq)
    else begin
        protocolCount++;
        $display("cmdAck or rspReq was high right after reset");
    end

    ackNeedsReq: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(cmdAck) |-> $past(cmdReq)
    ) else begin
        protocolCount++;
        $display("cmdAck rose without cmdReq high");
    end

    // A second request must wait until the previous reply handshake is over
    oneCycleOpen: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(cmdAck) |-> $past(outstanding) == 0
    ) else begin
        protocolCount++;
        $display("cmdAck rose while a reply was still pending");
    end

    replyPerCycle: assert property (
        @(posedge clk) disable iff (!rstN)
        $rose(rspReq) |-> outstanding == 1
    ) else begin
        protocolCount++;
        $display("rspReq rose without exactly one accepted cycle waiting");
    end

    replyHeld: assert property (
        @(posedge clk) disable iff (!rstN)
        rspReq && !rspAck |=> rspReq && $stable(rspData)
    ) else begin
        protocolCount++;
        $display("rspReq dropped or rspData changed before rspAck");
    end

endmodule

// File: list.f
hw/memPkg.sv
hw/busPkg.sv
hw/cycleIntake.sv
hw/byteEnable.sv
hw/chipRamStore.sv
hw/cycleReply.sv
hw/chipRamTop.sv
bench/chipRamBench.sv
